/* bench/lfsr_ref.svh */
// testbench model functions for the LFSR word generator, included inside the testbench module
`ifndef LFSR_REF_SVH
`define LFSR_REF_SVH

  ////////////////////////////////////////////////////////////////////////////
  // register update
  ////////////////////////////////////////////////////////////////////////////

  // next state: seed load, then reseed out of zero, then Galois step, else hold
  function automatic lfsr_pkg::lfsr_word_t ref_step(input lfsr_pkg::lfsr_word_t state,
                                                    input lfsr_pkg::lfsr_ctrl_t ctrl,
                                                    input lfsr_pkg::lfsr_word_t seed);
    lfsr_pkg::lfsr_word_t nxt;
    nxt = state;
    if (ctrl.seed_en) begin
      nxt = seed;
    end else if (ctrl.step_en && state == '0) begin
      nxt = lfsr_pkg::DefaultSeed;
    end else if (ctrl.step_en) begin
      nxt = state >> 1;
      // taps only when a one falls out of bit 0
      if (state[0]) begin
        nxt = nxt ^ lfsr_pkg::LfsrCoeffs;
      end
      nxt = nxt ^ {24'h00_0000, ctrl.entropy};
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // output layer
  ////////////////////////////////////////////////////////////////////////////

  // PRINCE 4-bit S-box, written out entry by entry
  function automatic logic [3:0] ref_sbox(input logic [3:0] nib);
    logic [3:0] res;
    case (nib)
      4'h0: res = 4'hb;
      4'h1: res = 4'hf;
      4'h2: res = 4'h3;
      4'h3: res = 4'h2;
      4'h4: res = 4'ha;
      4'h5: res = 4'hc;
      4'h6: res = 4'h9;
      4'h7: res = 4'h1;
      4'h8: res = 4'h6;
      4'h9: res = 4'h7;
      4'ha: res = 4'h8;
      4'hb: res = 4'h0;
      4'hc: res = 4'he;
      4'hd: res = 4'h5;
      4'he: res = 4'hd;
      default: res = 4'h4;
    endcase
    return res;
  endfunction

  // state bits laid out in a 4x8 grid, columns shuffled, then read row by row
  function automatic lfsr_pkg::lfsr_word_t ref_out(input lfsr_pkg::lfsr_word_t state);
    int unsigned grid [0:3][0:7];
    int unsigned tmp [0:7];
    logic [3:0] nib;
    lfsr_pkg::lfsr_word_t res;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 8; r++) begin
        grid[c][r] = c * 8 + r;
      end
    end
    // col 1: entry k moves to (k+4) mod 8
    for (int k = 0; k < 8; k++) tmp[(k + 4) % 8] = grid[1][k];
    for (int k = 0; k < 8; k++) grid[1][k] = tmp[k];
    // col 2: reversed
    for (int k = 0; k < 8; k++) tmp[7 - k] = grid[2][k];
    for (int k = 0; k < 8; k++) grid[2][k] = tmp[k];
    // col 3: rotated by one, then reversed
    for (int k = 0; k < 8; k++) tmp[(k + 1) % 8] = grid[3][k];
    for (int k = 0; k < 8; k++) grid[3][7 - k] = tmp[k];
    // sbox k, input b sits at position 4k+b -> column b, row k
    for (int k = 0; k < 8; k++) begin
      for (int b = 0; b < 4; b++) begin
        nib[b] = state[grid[b][k]];
      end
      res[4*k +: 4] = ref_sbox(nib);
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus source
  ////////////////////////////////////////////////////////////////////////////

  // taps of the stimulus LFSR, independent of the DUT polynomial
  localparam logic [31:0] StimTaps = 32'ha300_0000;

  // one Galois step, right shift
  function automatic logic [31:0] galois_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ StimTaps) : (s >> 1);
  endfunction

`endif

/* bench/lfsr_gen_tb.sv */
// testbench for the LFSR word generator, drives control sequences and compares rnd_o with a model
`default_nettype none
`timescale 1ns/1ps

module lfsr_gen_tb;

  // clock period in ns
  localparam int unsigned ClkPeriod    = 8;
  // start value of the stimulus LFSR
  localparam logic [31:0] StimSeed     = 32'hf65d_b628;
  localparam int unsigned StepCycles   = 200;
  localparam int unsigned HoldCycles   = 20;
  localparam int unsigned RandCycles   = 300;
  // edges allowed for the checker to catch up at the end
  localparam int unsigned DrainTimeout = 10;
  // hard limit on the whole run, in cycles
  localparam int unsigned RunLimit     = 2000;

  logic                 clk;
  logic                 rst_n;
  lfsr_pkg::lfsr_ctrl_t ctrl;
  lfsr_pkg::lfsr_word_t seed;
  lfsr_pkg::lfsr_word_t rnd;

  // model state, mirrors the DUT register
  lfsr_pkg::lfsr_word_t shadow;
  // stimulus LFSR state
  logic [31:0]          stim_state;
  int unsigned          n_checks;

  `include "lfsr_ref.svh"

  lfsr_gen_top dut (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .ctrl_i (ctrl),
    .seed_i (seed),
    .rnd_o  (rnd)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input string what, input lfsr_pkg::lfsr_word_t exp,
                            input lfsr_pkg::lfsr_word_t act);
    assert (act === exp) else begin
      $display("error: %s expected %h actual %h", what, exp, act);
      $display("Checks failed");
      $fatal(1, "value mismatch on %s", what);
    end
  endtask

  // n bits, msb first, one LFSR step per bit
  task automatic rand_bits(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val = {val[30:0], stim_state[0]};
      stim_state = galois_next(stim_state);
    end
  endtask

  // new inputs 1 ns after the next rising edge
  task automatic apply(input logic se, input logic st, input logic [7:0] ent,
                       input lfsr_pkg::lfsr_word_t s);
    @(posedge clk);
    #1;
    ctrl.seed_en = se;
    ctrl.step_en = st;
    ctrl.entropy = ent;
    seed = s;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // comparing process
  ////////////////////////////////////////////////////////////////////////////

  // model takes the inputs seen at the edge, output checked mid-cycle
  initial begin : compare
    n_checks = 0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        shadow = lfsr_pkg::DefaultSeed;
      end else begin
        shadow = ref_step(shadow, ctrl, seed);
      end
      #2;
      check_word("rnd_o", ref_out(shadow), rnd);
      n_checks++;
    end
  end

  initial begin : watchdog
    #(RunLimit * ClkPeriod);
    $display("timeout: run did not finish within the cycle limit");
    $display("Checks failed");
    $fatal(1, "run limit reached");
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    lfsr_pkg::lfsr_word_t held;
    lfsr_pkg::lfsr_ctrl_t step_only;
    logic [31:0] r_se;
    logic [31:0] r_st;
    logic [31:0] r_ent;
    logic [31:0] r_seed;
    int unsigned target;
    int unsigned guard;

    stim_state = StimSeed;
    rst_n = 1'b0;
    ctrl = '0;
    seed = '0;
    step_only = '0;
    step_only.step_en = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle after reset shows the image of the default seed
    for (int i = 0; i < 6; i++) begin
      apply(1'b0, 1'b0, 8'h00, '0);
      check_word("rnd_o", ref_out(lfsr_pkg::DefaultSeed), rnd);
    end

    // plain stepping, the checker follows every edge
    for (int i = 0; i < StepCycles; i++) begin
      apply(1'b0, 1'b1, 8'h00, '0);
    end

    // step_en low freezes the word whatever else moves
    apply(1'b0, 1'b0, 8'h00, '0);
    // model word after the last enabled step
    held = ref_out(shadow);
    for (int i = 0; i < HoldCycles; i++) begin
      rand_bits(8, r_ent);
      rand_bits(32, r_seed);
      apply(1'b0, 1'b0, r_ent[7:0], r_seed);
      check_word("rnd_o", held, rnd);
    end

    // seed load wins over a step in the same cycle
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, r_seed);
      rand_bits(8, r_ent);
      apply(1'b1, 1'b1, r_ent[7:0], r_seed);
      apply(1'b0, 1'b0, 8'h00, '0);
      check_word("rnd_o", ref_out(r_seed), rnd);
    end

    // zero seed, then reseed, then a normal step from the default seed
    apply(1'b1, 1'b0, 8'h00, '0);
    apply(1'b0, 1'b1, 8'h00, '0);
    check_word("rnd_o", ref_out('0), rnd);
    apply(1'b0, 1'b1, 8'h00, '0);
    check_word("rnd_o", ref_out(lfsr_pkg::DefaultSeed), rnd);
    apply(1'b0, 1'b0, 8'h00, '0);
    check_word("rnd_o", ref_out(ref_step(lfsr_pkg::DefaultSeed, step_only, '0)), rnd);

    // random mix, seed strobe about once in sixteen cycles
    for (int i = 0; i < RandCycles; i++) begin
      rand_bits(4, r_se);
      rand_bits(1, r_st);
      rand_bits(8, r_ent);
      rand_bits(32, r_seed);
      apply(r_se[3:0] == 4'h0, r_st[0], r_ent[7:0], r_seed);
    end
    apply(1'b0, 1'b0, 8'h00, '0);

    // let the checker see the last inputs
    target = n_checks + 2;
    guard = 0;
    while (n_checks < target && guard < DrainTimeout) begin
      @(posedge clk);
      guard++;
    end
    #3;

    if (n_checks >= target) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("timeout: checker stopped comparing");
      $display("Checks failed");
      $fatal(1, "checker did not finish");
    end
  end

endmodule

`default_nettype wire

/* design/lfsr_gen_top.sv */
// top of the 32-bit random word generator: state register followed by the S-box output layer
`default_nettype none
`timescale 1ns/1ps

module lfsr_gen_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // seed strobe, step enable and entropy for this cycle
  input  lfsr_pkg::lfsr_ctrl_t ctrl_i,
  // value taken on a seed strobe
  input  lfsr_pkg::lfsr_word_t seed_i,
  // non-linear image of the registered state
  output lfsr_pkg::lfsr_word_t rnd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  // registered LFSR state, feeds only the output layer
  lfsr_pkg::lfsr_word_t state;

  // one register stage
  // controls sampled at an edge show up in state right after it
  lfsr_state_reg u_state_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .ctrl_i  (ctrl_i),
    .seed_i  (seed_i),
    .state_o (state)
  );

  // purely combinational, so rnd_o moves in the same cycle as state
  // holding step_en low freezes both
  lfsr_sbox_layer u_sbox_layer (
    .state_i (state),
    .rnd_o   (rnd_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // notes
  ////////////////////////////////////////////////////////////////////////////

  // no handshake
  // the word is valid every cycle once reset is released
  // after reset rnd_o is the S-box image of the default seed

endmodule

`default_nettype wire

/* design/lfsr_pkg.sv */
// shared widths, polynomial, seed, S-box table and control types for the LFSR word generator
`default_nettype none

package lfsr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // state and output word width
  localparam int unsigned LfsrDw    = 32;
  // entropy bits folded into the low end of the state on each step
  localparam int unsigned EntropyDw = 8;
  // one 4-bit S-box per nibble of state
  localparam int unsigned NumSboxes = LfsrDw / 4;
  // enough bits to address any state bit
  localparam int unsigned LfsrIdxDw = 5;

  ////////////////////////////////////////////////////////////////////////////
  // polynomial and seed
  ////////////////////////////////////////////////////////////////////////////

  // Galois feedback taps for 32 bits, msb set so a nonzero state stays nonzero
  localparam logic [LfsrDw-1:0] LfsrCoeffs  = 32'h8020_0003;
  // reset value, also reloaded when the state falls to all-zero
  localparam logic [LfsrDw-1:0] DefaultSeed = 32'h0000_0001;

  // state or output word
  typedef logic [LfsrDw-1:0] lfsr_word_t;

  // controls sampled on every rising edge
  typedef struct packed {
    // load seed_i into the state, wins over stepping
    logic                 seed_en;
    // advance the register by one step
    logic                 step_en;
    // xor'ed into state bits [EntropyDw-1:0] on a step
    logic [EntropyDw-1:0] entropy;
  } lfsr_ctrl_t;

  // what the register does at the next edge
  typedef enum logic [1:0] {
    HOLD,
    LOAD_SEED,
    RESEED,
    SHIFT
  } lfsr_step_e;

  ////////////////////////////////////////////////////////////////////////////
  // non-linear output layer
  ////////////////////////////////////////////////////////////////////////////

  // PRINCE 4-bit S-box, entry 0 in the low nibble
  // in index order: B F 3 2 A C 9 1 6 7 8 0 E 5 D 4
  localparam logic [15:0][3:0] PrinceSbox4 = 64'h4d5e_0876_19ca_23fb;

  // source state bit for S-box input position pos (0 .. LfsrDw-1)
  //
  // state bit j sits in column j / NumSboxes, row j % NumSboxes
  // then the columns are reshuffled so that a plain shift of the state
  // does not just move one S-box input group onto its neighbour
  //   col 0: untouched
  //   col 1: rotated down by half a column
  //   col 2: reversed
  //   col 3: rotated down by one, then reversed
  // S-box input pos reads column pos % 4, row pos / 4
  function automatic logic [LfsrIdxDw-1:0] sbox_src_idx(input int unsigned pos);
    int unsigned col;
    int unsigned row;
    int unsigned src_row;
    col = pos % 4;
    row = pos / 4;
    case (col)
      0: begin
        src_row = row;
      end
      1: begin
        // entry k lands on (k + NumSboxes/2), so row r came from r - NumSboxes/2
        src_row = (row + NumSboxes / 2) % NumSboxes;
      end
      2: begin
        src_row = NumSboxes - 1 - row;
      end
      default: begin
        // rotate by one gives old[r-1], reversing reads that at NumSboxes-1-r
        src_row = (2 * NumSboxes - 2 - row) % NumSboxes;
      end
    endcase
    return LfsrIdxDw'(col * NumSboxes + src_row);
  endfunction

endpackage

`default_nettype wire

/* design/lfsr_sbox_layer.sv */
// non-linear output layer: permutes the LFSR state into eight PRINCE S-boxes, combinational
`default_nettype none
`timescale 1ns/1ps

module lfsr_sbox_layer (
  input  lfsr_pkg::lfsr_word_t state_i,
  output lfsr_pkg::lfsr_word_t rnd_o
);

  ////////////////////////////////////////////////////////////////////////////
  // permutation sanity
  ////////////////////////////////////////////////////////////////////////////

  // marks every state bit that feeds some S-box input
  function automatic lfsr_pkg::lfsr_word_t src_cover();
    lfsr_pkg::lfsr_word_t mask;
    mask = '0;
    for (int unsigned p = 0; p < lfsr_pkg::LfsrDw; p++) begin
      mask[lfsr_pkg::sbox_src_idx(p)] = 1'b1;
    end
    return mask;
  endfunction

  // all ones when the index map hits each state bit exactly once
  localparam lfsr_pkg::lfsr_word_t SrcCover = src_cover();

  // an index map that drops a state bit would leave entropy unused
  if (SrcCover != '1) begin : gen_perm_err
    $error("S-box input map is not a permutation of the state bits");
  end

  ////////////////////////////////////////////////////////////////////////////
  // S-box array
  ////////////////////////////////////////////////////////////////////////////

  // for a 32-bit word the inputs come out as
  //   sbox0:  0, 12, 23, 30   sbox4:  4,  8, 19, 26
  //   sbox1:  1, 13, 22, 29   sbox5:  5,  9, 18, 25
  //   sbox2:  2, 14, 21, 28   sbox6:  6, 10, 17, 24
  //   sbox3:  3, 15, 20, 27   sbox7:  7, 11, 16, 31
  // so no two adjacent state bits share one S-box and a shift of the
  // state does not just slide one group onto the next
  for (genvar k = 0; k < lfsr_pkg::NumSboxes; k++) begin : gen_sbox

    // nibble gathered from four spread-out state bits
    logic [3:0] sbox_in;

    for (genvar b = 0; b < 4; b++) begin : gen_bit
      // fixed wiring, resolved at elaboration
      localparam logic [lfsr_pkg::LfsrIdxDw-1:0] SrcIdx = lfsr_pkg::sbox_src_idx(4 * k + b);
      assign sbox_in[b] = state_i[SrcIdx];
    end

    // table lookup, lands on the same nibble position it is numbered for
    assign rnd_o[4*k +: 4] = lfsr_pkg::PrinceSbox4[sbox_in];

  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // no clock here, so a deferred form settles once per time step
  // a known state must always give a known word, the table has no gaps
  rnd_known_a : assert final ($isunknown(state_i) || !$isunknown(rnd_o))
    else $error("rnd_o unknown for a known state");

endmodule

`default_nettype wire

/* design/lfsr_state_reg.sv */
// Galois XOR state register with entropy input, lockup reseed and external seed load
`default_nettype none
`timescale 1ns/1ps

module lfsr_state_reg (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  lfsr_pkg::lfsr_ctrl_t ctrl_i,
  input  lfsr_pkg::lfsr_word_t seed_i,
  output lfsr_pkg::lfsr_word_t state_o
);

  // current and next register value
  lfsr_pkg::lfsr_word_t state_q;
  lfsr_pkg::lfsr_word_t state_d;
  // value after one Galois step from state_q
  lfsr_pkg::lfsr_word_t shift_state;
  // entropy widened to the state width
  lfsr_pkg::lfsr_word_t entropy_ext;
  // feedback taps, live only when the bit shifted out was one
  lfsr_pkg::lfsr_word_t feedback;
  // all-zero state, the only one a XOR LFSR cannot leave on its own
  logic                 lockup;
  // selected update for this cycle
  lfsr_pkg::lfsr_step_e step_sel;

  ////////////////////////////////////////////////////////////////////////////
  // next-state logic
  ////////////////////////////////////////////////////////////////////////////

  assign entropy_ext = {{(lfsr_pkg::LfsrDw - lfsr_pkg::EntropyDw){1'b0}}, ctrl_i.entropy};

  // replicate bit 0 across the taps
  assign feedback = {lfsr_pkg::LfsrDw{state_q[0]}} & lfsr_pkg::LfsrCoeffs;

  // internal xor form, shift right with taps folded in
  assign shift_state = (state_q >> 1) ^ feedback ^ entropy_ext;

  assign lockup = ~(|state_q);

  // seed load first, then reseed out of lockup, then a normal step
  always_comb begin
    if (ctrl_i.seed_en) begin
      step_sel = lfsr_pkg::LOAD_SEED;
    end else if (ctrl_i.step_en && lockup) begin
      step_sel = lfsr_pkg::RESEED;
    end else if (ctrl_i.step_en) begin
      step_sel = lfsr_pkg::SHIFT;
    end else begin
      step_sel = lfsr_pkg::HOLD;
    end
  end

  always_comb begin
    case (step_sel)
      lfsr_pkg::LOAD_SEED: begin
        // a zero seed is taken as is and reseeded on the next step
        state_d = seed_i;
      end
      lfsr_pkg::RESEED: begin
        state_d = lfsr_pkg::DefaultSeed;
      end
      lfsr_pkg::SHIFT: begin
        state_d = shift_state;
      end
      default: begin
        state_d = state_q;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lfsr_pkg::DefaultSeed;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // msb of the taps must be set, otherwise a nonzero state can decay to zero
  if (!lfsr_pkg::LfsrCoeffs[lfsr_pkg::LfsrDw-1]) begin : gen_coeff_err
    $error("LFSR polynomial needs its top bit set");
  end

  // reset value must not be the lockup state
  if (lfsr_pkg::DefaultSeed == '0) begin : gen_seed_err
    $error("LFSR default seed must be nonzero");
  end

  // a seed strobe shows up in the state one edge later, step_en or not
  seed_load_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.seed_en |=> (state_q == $past(seed_i)))
    else $error("seed_i not loaded into the state");

  // an enabled step taken out of lockup must leave lockup
  lockup_exit_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_i.step_en && !ctrl_i.seed_en && lockup) |=> !lockup)
    else $error("state stuck at zero after an enabled step");

  // without entropy or seed, a plain step never lands on zero
  no_lockup_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_sel inside {lfsr_pkg::SHIFT, lfsr_pkg::RESEED} && ctrl_i.entropy == '0)
    |=> !lockup)
    else $error("state entered lockup without external input");

endmodule

`default_nettype wire

/* lfsr_gen.f */
+incdir+bench
design/lfsr_pkg.sv
design/lfsr_state_reg.sv
design/lfsr_sbox_layer.sv
design/lfsr_gen_top.sv
bench/lfsr_gen_tb.sv
